//--- hdl/sample_buffer_pkg.sv
// shared widths, register map and bus types of the banked sample capture buffer
package sample_buffer_pkg;

  localparam int num_channels = 4;
  localparam int bank_depth = 16;
  localparam int sample_width = 16;
  localparam int max_banking_mode = 2;

  typedef logic [sample_width-1:0] sample_word_t;
  typedef logic [$clog2(bank_depth)-1:0] bank_addr_t;
  typedef logic [$clog2(bank_depth+1)-1:0] bank_depth_t;
  typedef logic [$clog2(num_channels)-1:0] bank_index_t;
  typedef logic [$clog2(max_banking_mode+1)-1:0] banking_mode_t;
  typedef logic [7:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // APB byte offsets, depth of bank b sits at reg_depth_base + 4*b
  localparam apb_addr_t reg_control = 8'h00;
  localparam apb_addr_t reg_banking = 8'h04;
  localparam apb_addr_t reg_status = 8'h08;
  localparam apb_addr_t reg_depth_base = 8'h0C;

  typedef struct packed {
    logic [num_channels-1:0] valid;
    sample_word_t [num_channels-1:0] data;
  } capture_samples_t;

  // single cycle command pulses plus the held banking mode
  typedef struct packed {
    logic capture_start;
    logic capture_stop;
    logic readout_start;
    logic sw_reset;
    banking_mode_t banking_mode;
  } buffer_cmd_t;

  // capturing lands in bit 0 of the status register
  typedef struct packed {
    logic readout_done;
    logic readout_busy;
    logic full;
    logic capturing;
  } buffer_status_t;

  typedef struct packed {
    logic en;
    bank_addr_t addr;
    sample_word_t data;
  } bank_write_t;

  typedef struct packed {
    bank_depth_t [num_channels-1:0] depth;
  } bank_depths_t;

  typedef enum logic {cap_idle, cap_armed} capture_state_t;

  typedef enum logic [1:0] {rd_idle, rd_fetch, rd_stream, rd_done} readout_state_t;

endpackage

//--- hdl/sample_buffer_regs.sv
// APB register block holding the banking mode and issuing capture and readout commands
`timescale 1ns/1ns
module sample_buffer_regs (
  input  logic                              capture_clk,
  input  logic                              readout_reset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  sample_buffer_pkg::apb_addr_t      paddr,
  input  sample_buffer_pkg::apb_data_t      pwdata,
  output sample_buffer_pkg::apb_data_t      prdata,
  output logic                              pready,
  output logic                              pslverr,
  output sample_buffer_pkg::buffer_cmd_t    cmd,
  input  sample_buffer_pkg::buffer_status_t status,
  input  sample_buffer_pkg::bank_depths_t   depths
);

  logic access;
  logic is_control;
  logic is_banking;
  logic is_status;
  logic is_depth;
  logic mapped;
  logic read_only;
  logic wr_control;
  logic wr_banking;
  sample_buffer_pkg::bank_index_t depth_sel;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  // access phase of a transfer, pready is tied high
  assign access = psel & penable;
  assign pready = 1'b1;

  assign is_control = paddr == sample_buffer_pkg::reg_control;
  assign is_banking = paddr == sample_buffer_pkg::reg_banking;
  assign is_status = paddr == sample_buffer_pkg::reg_status;
  assign is_depth = (paddr >= sample_buffer_pkg::reg_depth_base)
                  && (paddr < sample_buffer_pkg::reg_depth_base
                      + 4 * sample_buffer_pkg::num_channels)
                  && (paddr[1:0] == 2'b00);

  // word index of the depth register being addressed
  assign depth_sel = sample_buffer_pkg::bank_index_t'(
                       (paddr - sample_buffer_pkg::reg_depth_base) >> 2);

  assign mapped = is_control | is_banking | is_status | is_depth;
  assign read_only = is_status | is_depth;

  // unmapped offsets and writes to status or depth are errors
  assign pslverr = access & (~mapped | (pwrite & read_only));

  assign wr_control = access & pwrite & is_control;
  assign wr_banking = access & pwrite & is_banking;

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    prdata = '0;
    if (is_banking) begin
      prdata = sample_buffer_pkg::apb_data_t'(cmd.banking_mode);
    end else if (is_status) begin
      prdata = sample_buffer_pkg::apb_data_t'(status);
    end else if (is_depth) begin
      prdata = sample_buffer_pkg::apb_data_t'(depths.depth[depth_sel]);
    end
  end

  ////////////////////////////////////////////////////////////
  // command pulses and banking mode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (readout_reset) begin
      cmd <= '0;
    end else begin
      // control bits only live for one cycle
      cmd.capture_start <= wr_control & pwdata[0];
      cmd.capture_stop <= wr_control & pwdata[1];
      cmd.readout_start <= wr_control & pwdata[2];
      cmd.sw_reset <= wr_control & pwdata[3];
      // mode is frozen during capture and out of range values are dropped
      if (wr_banking && !status.capturing
          && (pwdata <= sample_buffer_pkg::apb_data_t'(sample_buffer_pkg::max_banking_mode))) begin
        cmd.banking_mode <= sample_buffer_pkg::banking_mode_t'(pwdata);
      end
    end
  end

endmodule

//--- hdl/bank_capture.sv
// capture controller steering channel samples into banks and counting bank write depths
`timescale 1ns/1ns
module bank_capture (
  input  logic                                capture_clk,
  input  logic                                readout_reset,
  input  sample_buffer_pkg::buffer_cmd_t      cmd,
  input  sample_buffer_pkg::capture_samples_t samples,
  output sample_buffer_pkg::bank_write_t      bank_wr [sample_buffer_pkg::num_channels],
  output sample_buffer_pkg::bank_depths_t     depths,
  output logic                                capturing,
  output logic                                full
);

  // per channel pointer spanning all banks owned by that channel
  typedef logic [$bits(sample_buffer_pkg::bank_index_t)
                 + $bits(sample_buffer_pkg::bank_addr_t)-1:0] chan_ptr_t;

  sample_buffer_pkg::capture_state_t state;
  chan_ptr_t wr_ptr [sample_buffer_pkg::num_channels];
  chan_ptr_t last_ptr;
  logic [sample_buffer_pkg::num_channels-1:0] chan_active;
  logic [sample_buffer_pkg::num_channels-1:0] chan_space;
  logic [sample_buffer_pkg::num_channels-1:0] chan_write;
  logic [sample_buffer_pkg::num_channels-1:0] chan_last;
  logic any_last;

  assign capturing = state == sample_buffer_pkg::cap_armed;

  ////////////////////////////////////////////////////////////
  // channel qualification
  ////////////////////////////////////////////////////////////

  always_comb begin
    // highest pointer value a channel reaches under this mode
    last_ptr = chan_ptr_t'((sample_buffer_pkg::bank_depth
                * (sample_buffer_pkg::num_channels >> cmd.banking_mode)) - 1);
    for (int c = 0; c < sample_buffer_pkg::num_channels; c++) begin
      chan_active[c] = c < (1 << cmd.banking_mode);
      // the last bank of a channel decides whether it still has room
      chan_space[c] = depths.depth[sample_buffer_pkg::bank_index_t'(
                        c + sample_buffer_pkg::num_channels - (1 << cmd.banking_mode))]
                      != sample_buffer_pkg::bank_depth;
      chan_write[c] = capturing & samples.valid[c] & chan_active[c] & chan_space[c];
      chan_last[c] = chan_write[c] & (wr_ptr[c] == last_ptr);
    end
    any_last = |chan_last;
  end

  ////////////////////////////////////////////////////////////
  // bank write steering
  ////////////////////////////////////////////////////////////

  always_comb begin
    sample_buffer_pkg::bank_index_t owner;
    sample_buffer_pkg::bank_index_t slot;
    for (int b = 0; b < sample_buffer_pkg::num_channels; b++) begin
      // bank b belongs to channel b mod 2^mode as its (b >> mode)th bank
      owner = sample_buffer_pkg::bank_index_t'(b & ((1 << cmd.banking_mode) - 1));
      slot = sample_buffer_pkg::bank_index_t'(b >> cmd.banking_mode);
      bank_wr[b].en = chan_write[owner]
                    & (sample_buffer_pkg::bank_index_t'(
                         wr_ptr[owner] >> $bits(sample_buffer_pkg::bank_addr_t)) == slot);
      bank_wr[b].addr = sample_buffer_pkg::bank_addr_t'(wr_ptr[owner]);
      bank_wr[b].data = samples.data[owner];
    end
  end

  ////////////////////////////////////////////////////////////
  // state, pointers and depths
  ////////////////////////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (readout_reset || cmd.sw_reset) begin
      state <= sample_buffer_pkg::cap_idle;
      full <= 1'b0;
      depths <= '0;
      for (int c = 0; c < sample_buffer_pkg::num_channels; c++) begin
        wr_ptr[c] <= '0;
      end
    end else if (cmd.capture_start) begin
      // a new capture starts from empty banks
      state <= sample_buffer_pkg::cap_armed;
      full <= 1'b0;
      depths <= '0;
      for (int c = 0; c < sample_buffer_pkg::num_channels; c++) begin
        wr_ptr[c] <= '0;
      end
    end else begin
      if (cmd.capture_stop || any_last) begin
        state <= sample_buffer_pkg::cap_idle;
      end
      if (any_last) begin
        full <= 1'b1;
      end
      for (int c = 0; c < sample_buffer_pkg::num_channels; c++) begin
        if (chan_write[c]) begin
          wr_ptr[c] <= wr_ptr[c] + 1'b1;
        end
      end
      for (int b = 0; b < sample_buffer_pkg::num_channels; b++) begin
        if (bank_wr[b].en) begin
          depths.depth[b] <= depths.depth[b] + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/bank_memory.sv
// one bank of simple dual port sample storage with a registered read port
`timescale 1ns/1ns
module bank_memory (
  input  logic                            capture_clk,
  input  sample_buffer_pkg::bank_write_t  wr,
  input  sample_buffer_pkg::bank_addr_t   rd_addr,
  output sample_buffer_pkg::sample_word_t rd_data
);

  ////////////////////////////////////////////////////////////
  // storage array
  ////////////////////////////////////////////////////////////

  sample_buffer_pkg::sample_word_t mem [sample_buffer_pkg::bank_depth];

  // write port driven by the capture controller
  always_ff @(posedge capture_clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // one cycle read latency
  // a read of the address being written returns the old word
  always_ff @(posedge capture_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hdl/bank_readout.sv
// readout sequencer walking the written words of every bank into a valid/ready stream
`timescale 1ns/1ns
module bank_readout (
  input  logic                            capture_clk,
  input  logic                            readout_reset,
  input  sample_buffer_pkg::buffer_cmd_t  cmd,
  input  sample_buffer_pkg::bank_depths_t depths,
  output sample_buffer_pkg::bank_addr_t   rd_addr,
  input  sample_buffer_pkg::sample_word_t bank_rd_data [sample_buffer_pkg::num_channels],
  output logic                            readout_valid,
  output sample_buffer_pkg::sample_word_t readout_data,
  output logic                            readout_last,
  input  logic                            readout_ready,
  output logic                            busy,
  output logic                            done
);

  sample_buffer_pkg::readout_state_t state;
  sample_buffer_pkg::bank_index_t bank;
  sample_buffer_pkg::bank_addr_t addr;
  sample_buffer_pkg::bank_index_t later_bank;
  logic later_hit;
  logic bank_empty;
  logic tail_word;
  logic final_word;

  // lowest nonempty bank at or above first, hit flag in the top bit
  function automatic logic [$bits(sample_buffer_pkg::bank_index_t):0] find_bank(
    input sample_buffer_pkg::bank_depths_t d,
    input int first
  );
    logic [$bits(sample_buffer_pkg::bank_index_t):0] hit;
    hit = '0;
    for (int b = sample_buffer_pkg::num_channels - 1; b >= 0; b--) begin
      if ((b >= first) && (d.depth[b] != '0)) begin
        hit = {1'b1, sample_buffer_pkg::bank_index_t'(b)};
      end
    end
    return hit;
  endfunction

  ////////////////////////////////////////////////////////////
  // position within the buffer
  ////////////////////////////////////////////////////////////

  always_comb begin
    {later_hit, later_bank} = find_bank(depths, int'(bank) + 1);
    bank_empty = depths.depth[bank] == '0;
    tail_word = {1'b0, addr} == (depths.depth[bank] - 1'b1);
    // nothing left after this word in any bank
    final_word = tail_word & ~later_hit;
  end

  assign rd_addr = addr;
  assign readout_valid = state == sample_buffer_pkg::rd_stream;
  assign readout_data = bank_rd_data[bank];
  assign readout_last = readout_valid & final_word;
  assign busy = (state == sample_buffer_pkg::rd_fetch)
              | (state == sample_buffer_pkg::rd_stream);
  assign done = state == sample_buffer_pkg::rd_done;

  ////////////////////////////////////////////////////////////
  // sequencer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (readout_reset || cmd.sw_reset) begin
      state <= sample_buffer_pkg::rd_idle;
      bank <= '0;
      addr <= '0;
    end else if (cmd.readout_start) begin
      state <= sample_buffer_pkg::rd_fetch;
      bank <= '0;
      addr <= '0;
    end else begin
      case (state)
        sample_buffer_pkg::rd_fetch: begin
          // only bank 0 can be empty here, later banks are chosen nonempty
          if (bank_empty) begin
            if (later_hit) begin
              bank <= later_bank;
            end else begin
              state <= sample_buffer_pkg::rd_done;
            end
          end else begin
            // memory output is valid on the next cycle
            state <= sample_buffer_pkg::rd_stream;
          end
        end
        sample_buffer_pkg::rd_stream: begin
          // word and address hold while the sink stalls
          if (readout_ready) begin
            if (final_word) begin
              state <= sample_buffer_pkg::rd_done;
            end else if (tail_word) begin
              bank <= later_bank;
              addr <= '0;
              state <= sample_buffer_pkg::rd_fetch;
            end else begin
              addr <= addr + 1'b1;
              state <= sample_buffer_pkg::rd_fetch;
            end
          end
        end
        default: begin
          state <= state;
        end
      endcase
    end
  end

endmodule

//--- hdl/sample_buffer.sv
// banked sample capture buffer top with APB control and streaming readout
`timescale 1ns/1ns
module sample_buffer (
  input  logic                                capture_clk,
  input  logic                                readout_reset,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  sample_buffer_pkg::apb_addr_t        paddr,
  input  sample_buffer_pkg::apb_data_t        pwdata,
  output sample_buffer_pkg::apb_data_t        prdata,
  output logic                                pready,
  output logic                                pslverr,
  input  sample_buffer_pkg::capture_samples_t samples,
  output logic                                readout_valid,
  output sample_buffer_pkg::sample_word_t     readout_data,
  output logic                                readout_last,
  input  logic                                readout_ready
);

  sample_buffer_pkg::buffer_cmd_t cmd;
  wire sample_buffer_pkg::buffer_status_t status;
  sample_buffer_pkg::bank_depths_t depths;
  sample_buffer_pkg::bank_write_t bank_wr [sample_buffer_pkg::num_channels];
  sample_buffer_pkg::bank_addr_t rd_addr;
  sample_buffer_pkg::sample_word_t bank_rd_data [sample_buffer_pkg::num_channels];

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  sample_buffer_regs i_regs (
    .capture_clk   (capture_clk),
    .readout_reset (readout_reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .cmd           (cmd),
    .status        (status),
    .depths        (depths)
  );

  bank_capture i_capture (
    .capture_clk   (capture_clk),
    .readout_reset (readout_reset),
    .cmd           (cmd),
    .samples       (samples),
    .bank_wr       (bank_wr),
    .depths        (depths),
    .capturing     (status.capturing),
    .full          (status.full)
  );

  ////////////////////////////////////////////////////////////
  // storage and readout
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < sample_buffer_pkg::num_channels; b++) begin : g_bank
    bank_memory i_bank (
      .capture_clk (capture_clk),
      .wr          (bank_wr[b]),
      .rd_addr     (rd_addr),
      .rd_data     (bank_rd_data[b])
    );
  end

  bank_readout i_readout (
    .capture_clk   (capture_clk),
    .readout_reset (readout_reset),
    .cmd           (cmd),
    .depths        (depths),
    .rd_addr       (rd_addr),
    .bank_rd_data  (bank_rd_data),
    .readout_valid (readout_valid),
    .readout_data  (readout_data),
    .readout_last  (readout_last),
    .readout_ready (readout_ready),
    .busy          (status.readout_busy),
    .done          (status.readout_done)
  );

endmodule

//--- sim/sample_buffer_tb.sv
// table-driven testbench for the banked sample capture buffer over APB, sample input and stream
`timescale 1ns/1ns
module sample_buffer_tb;

  localparam int num_rows = 8;
  localparam int cycle_limit = num_rows * 400 + 100;
  localparam int chan_words_max = sample_buffer_pkg::num_channels * sample_buffer_pkg::bank_depth;

  typedef struct {
    string name;
    int mode;
    int edges;
    bit sw_reset;
  } test_row_t;

  logic capture_clk = 1'b0;
  logic readout_reset;
  logic psel;
  logic penable;
  logic pwrite;
  sample_buffer_pkg::apb_addr_t paddr;
  sample_buffer_pkg::apb_data_t pwdata;
  sample_buffer_pkg::apb_data_t prdata;
  logic pready;
  logic pslverr;
  sample_buffer_pkg::capture_samples_t samples;
  logic readout_valid;
  sample_buffer_pkg::sample_word_t readout_data;
  logic readout_last;
  logic readout_ready;

  test_row_t rows [num_rows];
  string test_name;
  int cycle_count = 0;
  // reference model of what each channel should have kept
  sample_buffer_pkg::sample_word_t chan_words [sample_buffer_pkg::num_channels][chan_words_max];
  int chan_count [sample_buffer_pkg::num_channels];
  logic full_exp;
  sample_buffer_pkg::bank_depth_t exp_depth [sample_buffer_pkg::num_channels];
  sample_buffer_pkg::sample_word_t exp_words [$];

  sample_buffer i_dut (
    .capture_clk   (capture_clk),
    .readout_reset (readout_reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .samples       (samples),
    .readout_valid (readout_valid),
    .readout_data  (readout_data),
    .readout_last  (readout_last),
    .readout_ready (readout_ready)
  );

  always #10 capture_clk = ~capture_clk;

  always @(posedge capture_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run timed out after %0d cycles in %s", cycle_limit, test_name);
      fail_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input sample_buffer_pkg::sample_word_t exp,
                            input sample_buffer_pkg::sample_word_t act);
    if (exp !== act) begin
      $display("** Error: %s word expected %h actual %h", test_name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_depth(input sample_buffer_pkg::bank_depth_t exp,
                             input sample_buffer_pkg::bank_depth_t act);
    if (exp !== act) begin
      $display("** Error: %s depth expected %0d actual %0d", test_name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_status(input sample_buffer_pkg::buffer_status_t exp,
                              input sample_buffer_pkg::buffer_status_t act);
    if (exp !== act) begin
      $display("** Error: %s status expected %b actual %b", test_name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_apb_data(input sample_buffer_pkg::apb_data_t exp,
                                input sample_buffer_pkg::apb_data_t act);
    if (exp !== act) begin
      $display("** Error: %s register expected %h actual %h", test_name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flag(input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error: %s flag expected %b actual %b", test_name, exp, act);
      fail_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////

  // setup, access, then sample in the middle of the access phase
  task automatic apb_access(input logic write, input sample_buffer_pkg::apb_addr_t addr,
                            input sample_buffer_pkg::apb_data_t wdata,
                            output sample_buffer_pkg::apb_data_t rdata, output logic err);
    @(posedge capture_clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge capture_clk);
    penable <= 1'b1;
    @(negedge capture_clk);
    rdata = prdata;
    err = pslverr;
    // every transfer completes in its first access cycle
    check_flag(1'b1, pready);
    @(posedge capture_clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input sample_buffer_pkg::apb_addr_t addr,
                           input sample_buffer_pkg::apb_data_t wdata);
    sample_buffer_pkg::apb_data_t rdata;
    logic err;
    apb_access(1'b1, addr, wdata, rdata, err);
    check_flag(1'b0, err);
  endtask

  task automatic reg_read(input sample_buffer_pkg::apb_addr_t addr,
                          output sample_buffer_pkg::apb_data_t rdata);
    logic err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_flag(1'b0, err);
  endtask

  task automatic wait_status_bit(input int bit_idx);
    sample_buffer_pkg::apb_data_t d;
    d = '0;
    while (d[bit_idx] !== 1'b1) begin
      reg_read(sample_buffer_pkg::reg_status, d);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sample driver, model and stream sink
  ////////////////////////////////////////////////////////////

  task automatic drive_samples(input int edges, input int n_act, input int cap);
    sample_buffer_pkg::capture_samples_t stim;
    logic armed;
    logic hit_full;
    armed = 1'b1;
    for (int e = 0; e < edges; e++) begin
      @(posedge capture_clk);
      stim.valid = 4'($urandom | $urandom);
      for (int c = 0; c < sample_buffer_pkg::num_channels; c++) begin
        stim.data[c] = 16'($urandom);
      end
      samples <= stim;
      hit_full = 1'b0;
      for (int c = 0; c < n_act; c++) begin
        if (armed && stim.valid[c] && chan_count[c] < cap) begin
          chan_words[c][chan_count[c]] = stim.data[c];
          chan_count[c]++;
          hit_full = hit_full | (chan_count[c] == cap);
        end
      end
      // a filled channel ends the capture for every channel
      if (hit_full) begin
        armed = 1'b0;
        full_exp = 1'b1;
      end
    end
    @(posedge capture_clk);
    samples <= '0;
  endtask

  // channel c owns banks c, c + n_act, ... filled in order
  task automatic build_expected(input int n_act);
    int c;
    int slot;
    exp_words.delete();
    for (int b = 0; b < sample_buffer_pkg::num_channels; b++) begin
      c = b % n_act;
      slot = b / n_act;
      exp_depth[b] = '0;
      for (int i = slot * sample_buffer_pkg::bank_depth;
           i < chan_count[c] && i < (slot + 1) * sample_buffer_pkg::bank_depth; i++) begin
        exp_words.push_back(chan_words[c][i]);
        exp_depth[b] = exp_depth[b] + 1'b1;
      end
    end
  endtask

  task automatic collect_stream();
    int got;
    logic held;
    sample_buffer_pkg::sample_word_t held_word;
    got = 0;
    held = 1'b0;
    while (got < exp_words.size()) begin
      @(posedge capture_clk);
      readout_ready <= ($urandom % 4) != 0;
      @(negedge capture_clk);
      if (held) begin
        if (readout_valid !== 1'b1) begin
          $display("%s: readout_valid dropped before the word was taken", test_name);
          fail_run();
        end
        check_word(held_word, readout_data);
      end
      held = readout_valid & ~readout_ready;
      held_word = readout_data;
      if (readout_valid && readout_ready) begin
        check_word(exp_words[got], readout_data);
        check_flag(got == exp_words.size() - 1, readout_last);
        got++;
      end
    end
    @(posedge capture_clk);
    readout_ready <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    sample_buffer_pkg::apb_data_t d;
    sample_buffer_pkg::buffer_status_t exp_st;
    sample_buffer_pkg::buffer_status_t act_st;
    logic err;
    int mode;
    int n_act;
    int cap;
    void'($urandom(32'h809c_5200));
    rows[0] = '{"mode0_short", 0, 20, 1'b0};
    rows[1] = '{"mode1_short", 1, 12, 1'b0};
    rows[2] = '{"mode2_short", 2, 8, 1'b0};
    rows[3] = '{"mode2_overflow", 2, 30, 1'b0};
    rows[4] = '{"mode1_overflow", 1, 56, 1'b0};
    rows[5] = '{"mode0_overflow", 0, 100, 1'b0};
    rows[6] = '{"sw_reset_mid", 1, 10, 1'b1};
    rows[7] = '{"no_samples", 2, 0, 1'b0};
    readout_reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    samples = '0;
    readout_ready = 1'b0;
    repeat (16) @(posedge capture_clk);
    readout_reset <= 1'b0;

    test_name = "after_reset";
    @(negedge capture_clk);
    check_flag(1'b0, readout_valid);
    check_flag(1'b0, pslverr);
    reg_read(sample_buffer_pkg::reg_status, d);
    check_status('0, sample_buffer_pkg::buffer_status_t'(d[3:0]));

    test_name = "apb_map";
    apb_access(1'b0, 8'h40, '0, d, err);
    check_flag(1'b1, err);
    apb_access(1'b1, sample_buffer_pkg::reg_status, '0, d, err);
    check_flag(1'b1, err);

    for (int r = 0; r < num_rows; r++) begin
      test_name = rows[r].name;
      mode = rows[r].mode;
      n_act = 1 << mode;
      cap = sample_buffer_pkg::bank_depth * (sample_buffer_pkg::num_channels / n_act);
      for (int c = 0; c < sample_buffer_pkg::num_channels; c++) begin
        chan_count[c] = 0;
      end
      full_exp = 1'b0;
      reg_write(sample_buffer_pkg::reg_banking, mode);
      reg_read(sample_buffer_pkg::reg_banking, d);
      check_apb_data(mode, d);
      reg_write(sample_buffer_pkg::reg_control, 32'h1);
      wait_status_bit(0);
      // banking mode is frozen while capturing
      reg_write(sample_buffer_pkg::reg_banking, (mode + 1) % 3);
      reg_read(sample_buffer_pkg::reg_banking, d);
      check_apb_data(mode, d);
      drive_samples(rows[r].edges, n_act, cap);
      // a filled channel ends the capture on its own
      reg_read(sample_buffer_pkg::reg_status, d);
      act_st = sample_buffer_pkg::buffer_status_t'(d[3:0]);
      check_flag(~full_exp, act_st.capturing);
      check_flag(full_exp, act_st.full);
      if (rows[r].sw_reset) begin
        reg_write(sample_buffer_pkg::reg_control, 32'h8);
        for (int c = 0; c < sample_buffer_pkg::num_channels; c++) begin
          chan_count[c] = 0;
        end
        full_exp = 1'b0;
      end else begin
        reg_write(sample_buffer_pkg::reg_control, 32'h2);
      end
      build_expected(n_act);
      for (int b = 0; b < sample_buffer_pkg::num_channels; b++) begin
        reg_read(sample_buffer_pkg::apb_addr_t'(sample_buffer_pkg::reg_depth_base + 4 * b), d);
        check_depth(exp_depth[b], sample_buffer_pkg::bank_depth_t'(d));
      end
      reg_write(sample_buffer_pkg::reg_control, 32'h4);
      collect_stream();
      wait_status_bit(3);
      exp_st = '0;
      exp_st.readout_done = 1'b1;
      exp_st.full = full_exp;
      reg_read(sample_buffer_pkg::reg_status, d);
      check_status(exp_st, sample_buffer_pkg::buffer_status_t'(d[3:0]));
    end

    $display("Test OK");
    $finish;
  end

endmodule

//--- sample_buffer.f
hdl/sample_buffer_pkg.sv
hdl/sample_buffer_regs.sv
hdl/bank_capture.sv
hdl/bank_memory.sv
hdl/bank_readout.sv
hdl/sample_buffer.sv
sim/sample_buffer_tb.sv
